/* cache_pkg.sv */
// bus widths, wishbone request and response structs, cache controller state enum
package cache_pkg;

    localparam int addr_w = 16;              // byte address width
    localparam int data_w = 32;              // data width, one word per line
    localparam int sel_w  = data_w / 8;      // one select per byte lane

    // master to slave, wishbone classic
    typedef struct packed {
        logic              cyc;              // bus cycle in progress
        logic              stb;              // valid transfer
        logic              we;               // write when high
        logic [addr_w-1:0] adr;              // byte address
        logic [sel_w-1:0]  sel;              // byte lane selects
        logic [data_w-1:0] dat_m;            // write data
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic              ack;              // one cycle per transfer
        logic [data_w-1:0] dat_s;            // read data, valid with ack
    } wb_rsp_t;

    // l1 controller sequencing
    typedef enum logic [1:0] {
        st_idle,                             // wait for cpu request
        st_compare,                          // tag lookup, ack on hit
        st_writeback,                        // dirty victim to memory
        st_refill                            // fetch missing line
    } ctrl_state_e;

endpackage : cache_pkg

/* cache_l1_datapath.sv */
// two-way tag, data, valid, dirty and lru storage with hit detect, byte merge and memory steering
`timescale 1ns/1ps

module cache_l1_datapath #(
    parameter int set_bits = 4                        // index width
) (
    input  logic                           clk,
    input  logic                           arst_n,

    // controller to datapath
    input  logic                           way_sel,          // way being read or written
    input  logic                           data_source_sel,  // 1 cpu write merge, 0 memory
    input  logic                           tag_bypass_sel,   // 1 request address, 0 victim
    input  logic                           load,             // write selected way
    input  logic                           load_lru,         // mark selected way as used

    // cpu and memory data
    input  cache_pkg::wb_req_t             cpu_req,
    input  logic [cache_pkg::data_w-1:0]   mem_dat,

    // datapath to controller
    output logic                           hit_0,
    output logic                           hit_1,
    output logic                           dirty,            // dirty bit of selected way
    output logic                           lru,              // way to replace next

    // to cpu and memory
    output logic [cache_pkg::data_w-1:0]   cpu_dat,
    output logic [cache_pkg::addr_w-1:0]   mem_adr,
    output logic [cache_pkg::sel_w-1:0]    mem_sel,
    output logic [cache_pkg::data_w-1:0]   mem_dat_m
);
    import cache_pkg::*;

    localparam int sets  = 1 << set_bits;
    localparam int tag_w = addr_w - set_bits - 2;

    logic [tag_w-1:0]    tag_mem  [2][sets];           // stored tags per way
    logic [data_w-1:0]   data_mem [2][sets];           // one word per line
    logic [sets-1:0]     valid_q  [2];
    logic [sets-1:0]     dirty_q  [2];
    logic [sets-1:0]     lru_q;                        // holds index of lru way

    logic [set_bits-1:0] idx;
    logic [tag_w-1:0]    req_tag;
    logic [tag_w-1:0]    way_tag;
    logic [data_w-1:0]   way_data;
    logic [data_w-1:0]   merged;
    logic [data_w-1:0]   wr_data;

    // address split, bits 1..0 dropped
    assign idx     = cpu_req.adr[set_bits+1:2];
    assign req_tag = cpu_req.adr[addr_w-1:set_bits+2];

    assign hit_0 = valid_q[0][idx] && (tag_mem[0][idx] == req_tag);
    assign hit_1 = valid_q[1][idx] && (tag_mem[1][idx] == req_tag);

    assign way_tag  = tag_mem[way_sel][idx];           // victim tag on a miss
    assign way_data = data_mem[way_sel][idx];          // hit data or victim data
    assign dirty    = dirty_q[way_sel][idx];
    assign lru      = lru_q[idx];

    // cpu bytes over stored word
    always_comb begin
        for (int b = 0; b < sel_w; b++) begin
            merged[8*b +: 8] = cpu_req.sel[b] ? cpu_req.dat_m[8*b +: 8] : way_data[8*b +: 8];
        end
    end

    assign wr_data = data_source_sel ? merged : mem_dat;

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (load) begin
            tag_mem[way_sel][idx]  <= req_tag;         // same tag again on a write hit
            data_mem[way_sel][idx] <= wr_data;
        end
    end

    // line state bits
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            lru_q      <= '0;
        end else begin
            if (load) begin
                valid_q[way_sel][idx] <= 1'b1;
                dirty_q[way_sel][idx] <= data_source_sel;  // cpu write dirties, refill cleans
            end
            if (load_lru) begin
                lru_q[idx] <= ~way_sel;                // other way becomes lru
            end
        end
    end

    assign cpu_dat = way_data;

    // write-back goes to the victim's own address
    assign mem_adr = tag_bypass_sel ? {cpu_req.adr[addr_w-1:2], 2'b00}
                                    : {way_tag, idx, 2'b00};
    assign mem_sel   = {sel_w{1'b1}};                  // line transfers move the whole word
    assign mem_dat_m = way_data;                       // victim data for write-back

endmodule : cache_l1_datapath

/* cache_l1_controller.sv */
// l1 cache FSM for lookup, dirty victim write-back and refill, drives cpu ack and memory request
`timescale 1ns/1ps

module cache_l1_controller (
    input  logic clk,
    input  logic arst_n,

    // datapath to controller
    input  logic hit_0,
    input  logic hit_1,
    input  logic dirty,
    input  logic lru,

    // cpu side request
    input  logic cpu_cyc,
    input  logic cpu_stb,
    input  logic cpu_we,

    // memory side response
    input  logic mem_ack,

    // controller to datapath
    output logic way_sel,
    output logic data_source_sel,
    output logic tag_bypass_sel,
    output logic load,
    output logic load_lru,

    // cpu side response
    output logic cpu_ack,

    // memory side request
    output logic mem_cyc,
    output logic mem_stb,
    output logic mem_we
);
    import cache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        hit;
    logic        cpu_ack_d;

    assign hit = hit_0 | hit_1;

    // hit way, otherwise the lru way is the victim
    assign way_sel = hit_1 ? 1'b1 : (hit_0 ? 1'b0 : lru);

    always_comb begin
        state_d         = state_q;
        data_source_sel = 1'b0;
        tag_bypass_sel  = 1'b1;                        // request address by default
        load            = 1'b0;
        load_lru        = 1'b0;
        cpu_ack_d       = 1'b0;
        mem_cyc         = 1'b0;
        mem_stb         = 1'b0;
        mem_we          = 1'b0;
        case (state_q)
            st_idle: begin
                if (cpu_cyc && cpu_stb && !cpu_ack) begin  // skip request just acked
                    state_d = st_compare;
                end
            end
            st_compare: begin
                if (hit) begin
                    load            = cpu_we;          // write hit merges bytes
                    data_source_sel = 1'b1;
                    load_lru        = 1'b1;
                    cpu_ack_d       = 1'b1;
                    state_d         = st_idle;
                end else if (dirty) begin
                    state_d = st_writeback;
                end else begin
                    state_d = st_refill;
                end
            end
            st_writeback: begin
                mem_cyc        = 1'b1;
                mem_stb        = 1'b1;
                mem_we         = 1'b1;
                tag_bypass_sel = 1'b0;                 // victim address
                if (mem_ack) begin
                    state_d = st_refill;
                end
            end
            st_refill: begin
                mem_cyc = 1'b1;
                mem_stb = 1'b1;
                if (mem_ack) begin
                    load    = 1'b1;                    // memory data into victim way
                    state_d = st_compare;              // lookup again, now a hit
                end
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
            cpu_ack <= 1'b0;
        end else begin
            state_q <= state_d;
            cpu_ack <= cpu_ack_d;                      // ack one cycle after compare
        end
    end

endmodule : cache_l1_controller

/* cache_l1.sv */
// one l1 cache, datapath and controller joined through the cpu and memory structs
`timescale 1ns/1ps

module cache_l1 #(
    parameter int set_bits = 4
) (
    input  logic               clk,
    input  logic               arst_n,
    input  cache_pkg::wb_req_t cpu_req,                // from cpu
    output cache_pkg::wb_rsp_t cpu_rsp,                // to cpu
    output cache_pkg::wb_req_t mem_req,                // to arbiter
    input  cache_pkg::wb_rsp_t mem_rsp                 // from arbiter
);
    // controller to datapath
    logic way_sel;
    logic data_source_sel;
    logic tag_bypass_sel;
    logic load;
    logic load_lru;

    // datapath to controller
    logic hit_0;
    logic hit_1;
    logic dirty;
    logic lru;

    cache_l1_datapath #(
        .set_bits(set_bits)
    ) datapath_i (
        .clk,
        .arst_n,
        .way_sel,
        .data_source_sel,
        .tag_bypass_sel,
        .load,
        .load_lru,
        .cpu_req,
        .mem_dat   (mem_rsp.dat_s),
        .hit_0,
        .hit_1,
        .dirty,
        .lru,
        .cpu_dat   (cpu_rsp.dat_s),
        .mem_adr   (mem_req.adr),
        .mem_sel   (mem_req.sel),
        .mem_dat_m (mem_req.dat_m)
    );

    cache_l1_controller controller_i (
        .clk,
        .arst_n,
        .hit_0,
        .hit_1,
        .dirty,
        .lru,
        .cpu_cyc   (cpu_req.cyc),
        .cpu_stb   (cpu_req.stb),
        .cpu_we    (cpu_req.we),
        .mem_ack   (mem_rsp.ack),
        .way_sel,
        .data_source_sel,
        .tag_bypass_sel,
        .load,
        .load_lru,
        .cpu_ack   (cpu_rsp.ack),
        .mem_cyc   (mem_req.cyc),
        .mem_stb   (mem_req.stb),
        .mem_we    (mem_req.we)
    );

endmodule : cache_l1

/* mem_arbiter.sv */
// round-robin arbiter for two wishbone masters onto one memory, grant held until memory ack
`timescale 1ns/1ps

module mem_arbiter (
    input  logic               clk,
    input  logic               arst_n,
    input  cache_pkg::wb_req_t req_0,                  // cache 0 memory side
    input  cache_pkg::wb_req_t req_1,                  // cache 1 memory side
    output cache_pkg::wb_rsp_t rsp_0,
    output cache_pkg::wb_rsp_t rsp_1,
    output cache_pkg::wb_req_t mem_req,                // to main memory
    input  cache_pkg::wb_rsp_t mem_rsp
);
    logic busy_q;                                      // grant held
    logic last_q;                                      // last winner, granted port while busy
    logic want_0;
    logic want_1;
    logic pick;                                        // idle cycle winner
    logic sel;                                         // port on the memory bus
    logic active;
    logic gnt_0;
    logic gnt_1;

    assign want_0 = req_0.cyc & req_0.stb;
    assign want_1 = req_1.cyc & req_1.stb;

    // tie goes to the port that lost last time
    always_comb begin
        if (want_0 && want_1) begin
            pick = ~last_q;
        end else begin
            pick = want_1;
        end
    end

    assign sel    = busy_q ? last_q : pick;            // idle winner forwarded at once
    assign active = busy_q | want_0 | want_1;

    assign mem_req = !active ? '0 : (sel ? req_1 : req_0);

    assign gnt_0 = busy_q & ~last_q;
    assign gnt_1 = busy_q & last_q;

    // ack and data only to the granted port
    assign rsp_0.ack   = mem_rsp.ack & gnt_0;
    assign rsp_0.dat_s = gnt_0 ? mem_rsp.dat_s : '0;
    assign rsp_1.ack   = mem_rsp.ack & gnt_1;
    assign rsp_1.dat_s = gnt_1 ? mem_rsp.dat_s : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
            last_q <= 1'b0;
        end else if (!busy_q) begin
            if (want_0 || want_1) begin
                busy_q <= 1'b1;
                last_q <= pick;
            end
        end else if (mem_rsp.ack) begin
            busy_q <= 1'b0;                            // rearbitrate next cycle
        end
    end

endmodule : mem_arbiter

/* main_mem.sv */
// single-port word memory with byte-lane writes, registered read and one-cycle ack
`timescale 1ns/1ps

module main_mem #(
    parameter int mem_words_log2 = 10                  // words, address truncated to this
) (
    input  logic               clk,
    input  logic               arst_n,
    input  cache_pkg::wb_req_t mem_req,
    output cache_pkg::wb_rsp_t mem_rsp
);
    import cache_pkg::*;

    localparam int words = 1 << mem_words_log2;

    logic [data_w-1:0]         mem_q [words];
    logic [mem_words_log2-1:0] word_idx;
    logic                      access;                 // transfer accepted this cycle
    logic                      ack_q;
    logic [data_w-1:0]         rd_q;

    assign word_idx = mem_req.adr[mem_words_log2+1:2];
    assign access   = mem_req.cyc & mem_req.stb & ~ack_q;  // no new access in ack cycle

    // contents start at zero
    initial begin
        for (int i = 0; i < words; i++) begin
            mem_q[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (access && mem_req.we) begin
            for (int b = 0; b < sel_w; b++) begin
                if (mem_req.sel[b]) begin
                    mem_q[word_idx][8*b +: 8] <= mem_req.dat_m[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rd_q <= mem_q[word_idx];                   // old word on a write
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign mem_rsp.ack   = ack_q;
    assign mem_rsp.dat_s = rd_q;

endmodule : main_mem

/* cache_subsys.sv */
// two-port cache subsystem with two l1 caches, memory arbiter and shared main memory
`timescale 1ns/1ps

module cache_subsys #(
    parameter int set_bits       = 4,                  // index bits per cache
    parameter int mem_words_log2 = 10                  // main memory depth
) (
    input  logic               clk,
    input  logic               arst_n,
    input  cache_pkg::wb_req_t cpu0_req,
    output cache_pkg::wb_rsp_t cpu0_rsp,
    input  cache_pkg::wb_req_t cpu1_req,
    output cache_pkg::wb_rsp_t cpu1_rsp
);
    import cache_pkg::*;

    wb_req_t c0_mem_req;                               // cache 0 to arbiter
    wb_rsp_t c0_mem_rsp;
    wb_req_t c1_mem_req;                               // cache 1 to arbiter
    wb_rsp_t c1_mem_rsp;
    wb_req_t mem_req;                                  // arbiter to memory
    wb_rsp_t mem_rsp;

    cache_l1 #(
        .set_bits(set_bits)
    ) cache0_i (
        .clk,
        .arst_n,
        .cpu_req (cpu0_req),
        .cpu_rsp (cpu0_rsp),
        .mem_req (c0_mem_req),
        .mem_rsp (c0_mem_rsp)
    );

    cache_l1 #(
        .set_bits(set_bits)
    ) cache1_i (
        .clk,
        .arst_n,
        .cpu_req (cpu1_req),
        .cpu_rsp (cpu1_rsp),
        .mem_req (c1_mem_req),
        .mem_rsp (c1_mem_rsp)
    );

    mem_arbiter arbiter_i (
        .clk,
        .arst_n,
        .req_0   (c0_mem_req),
        .req_1   (c1_mem_req),
        .rsp_0   (c0_mem_rsp),
        .rsp_1   (c1_mem_rsp),
        .mem_req,
        .mem_rsp
    );

    main_mem #(
        .mem_words_log2(mem_words_log2)
    ) mem_i (
        .clk,
        .arst_n,
        .mem_req,
        .mem_rsp
    );

endmodule : cache_subsys

/* cache_checker.sv */
// checker for both cpu ports, ack rules and read data against the expected words
`timescale 1ns/1ps

module cache_checker (
    input  logic                         clk,
    input  logic                         arst_n,
    input  cache_pkg::wb_req_t           cpu0_req,
    input  cache_pkg::wb_rsp_t           cpu0_rsp,
    input  logic [cache_pkg::data_w-1:0] exp0_dat,     // expected word, port 0 read
    input  cache_pkg::wb_req_t           cpu1_req,
    input  cache_pkg::wb_rsp_t           cpu1_rsp,
    input  logic [cache_pkg::data_w-1:0] exp1_dat,     // expected word, port 1 read
    output int                           errors,
    output int                           reads_checked
);
    import cache_pkg::*;

    logic [1:0] req_seen = '0;                         // request up at the previous edge
    logic [1:0] ack_seen = '0;                         // ack up at the previous edge
    int         err_cnt  = 0;
    int         read_cnt = 0;

    assign errors        = err_cnt;
    assign reads_checked = read_cnt;

    // values read here are the ones from the cycle before this edge
    task automatic check_port(input int port, input wb_req_t req, input wb_rsp_t rsp,
                              input logic [data_w-1:0] exp_dat);
        if (rsp.ack && !req_seen[port]) begin
            $display("port %0d raised ack with no request pending at %0t", port, $time);
            err_cnt++;
        end
        if (rsp.ack && ack_seen[port]) begin
            $display("port %0d held ack longer than one cycle at %0t", port, $time);
            err_cnt++;
        end
        if (rsp.ack && !req.we) begin
            read_cnt++;
            if (rsp.dat_s !== exp_dat) begin
                $display("[FAIL] cpu%0d_rsp.dat_s = %h, expected %h, adr %h",
                         port, rsp.dat_s, exp_dat, req.adr);
                err_cnt++;
            end
        end
        req_seen[port] = req.cyc & req.stb;            // stb is held until ack is seen
        ack_seen[port] = rsp.ack;
    endtask

    always @(posedge clk) begin
        if (!arst_n && (cpu0_rsp.ack || cpu1_rsp.ack)) begin
            $display("cpu ack raised while in reset at %0t", $time);
            err_cnt++;
        end
        check_port(0, cpu0_req, cpu0_rsp, exp0_dat);
        check_port(1, cpu1_req, cpu1_rsp, exp1_dat);
    end

endmodule : cache_checker

/* tb_cache_subsys.sv */
// testbench top with clock, reset, stimulus for both cpu ports, reference model and checker
`timescale 1ns/1ps

module tb_cache_subsys;
    import cache_pkg::*;

    localparam int op_timeout = 200;                   // cycles allowed per access
    localparam int region_1   = 'h800;                 // port 1 region base

    logic              clk;
    logic              arst_n;
    wb_req_t           cpu_req [2];
    wb_rsp_t           cpu_rsp [2];
    logic [data_w-1:0] exp_dat [2];                    // expected word of current read
    logic [data_w-1:0] shadow [2][1024];               // per-port memory image
    integer            seed = 62211;
    int                tb_errors = 0;
    int                chk_errors;
    int                reads_checked;
    int                reads_issued = 0;               // reads driven on both ports
    int                lat;

    cache_subsys #(
        .set_bits       (4),
        .mem_words_log2 (10)
    ) cache_subsys_i (
        .clk,
        .arst_n,
        .cpu0_req (cpu_req[0]),
        .cpu0_rsp (cpu_rsp[0]),
        .cpu1_req (cpu_req[1]),
        .cpu1_rsp (cpu_rsp[1])
    );

    cache_checker checker_i (
        .clk,
        .arst_n,
        .cpu0_req      (cpu_req[0]),
        .cpu0_rsp      (cpu_rsp[0]),
        .exp0_dat      (exp_dat[0]),
        .cpu1_req      (cpu_req[1]),
        .cpu1_rsp      (cpu_rsp[1]),
        .exp1_dat      (exp_dat[1]),
        .errors        (chk_errors),
        .reads_checked (reads_checked)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                        // 100 ns period
    end

    // word after the access, a write merges its selected bytes first
    function automatic logic [data_w-1:0] ref_read(input int port, input logic [addr_w-1:0] adr,
                                                   input logic we, input logic [sel_w-1:0] sel,
                                                   input logic [data_w-1:0] dat);
        logic [9:0] w;
        w = adr[11:2];                                 // word index, 4 KB memory
        if (we) begin
            for (int b = 0; b < sel_w; b++) begin
                if (sel[b]) begin
                    shadow[port][w][8*b +: 8] = dat[8*b +: 8];
                end
            end
        end
        return shadow[port][w];
    endfunction

    // one request held until ack, lat counts falling edges from drive to ack
    task automatic bus_access(input int port, input logic we, input logic [addr_w-1:0] adr,
                              input logic [sel_w-1:0] sel, input logic [data_w-1:0] dat,
                              output int lat_out);
        wb_req_t r;
        int      cycles;
        r       = '0;
        r.cyc   = 1'b1;
        r.stb   = 1'b1;
        r.we    = we;
        r.adr   = adr;
        r.sel   = sel;
        r.dat_m = dat;
        @(negedge clk);
        exp_dat[port] = ref_read(port, adr, we, sel, dat);
        cpu_req[port] = r;
        if (!we) begin
            reads_issued++;                            // each read ack must reach the checker
        end
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cpu_rsp[port].ack && cycles < op_timeout);
        if (!cpu_rsp[port].ack) begin
            $display("port %0d got no ack within %0d cycles, adr %h", port, op_timeout, adr);
            tb_errors++;
        end
        lat_out = cycles;
        r.cyc   = 1'b0;                                // adr and data stay for the ack cycle
        r.stb   = 1'b0;
        cpu_req[port] = r;
    endtask

    task automatic random_ops(input int port, input integer start_seed, input int count);
        integer            s;
        logic [addr_w-1:0] adr;
        logic [data_w-1:0] dat;
        logic [sel_w-1:0]  sel;
        logic              we;
        int                l;
        s = start_seed;
        for (int i = 0; i < count; i++) begin
            adr = 16'(port * region_1 + ($random(s) & 32'h1fc));  // own region only
            we  = 1'($random(s));
            sel = 4'($random(s));
            dat = $random(s);
            bus_access(port, we, adr, sel, dat, l);
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        cpu_req[0] = '0;
        cpu_req[1] = '0;
        exp_dat[0] = '0;
        exp_dat[1] = '0;
        for (int i = 0; i < 1024; i++) begin
            shadow[0][i] = '0;
            shadow[1][i] = '0;
        end
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        repeat (4) begin                               // no ack while nothing is asked
            @(negedge clk);
            if (cpu_rsp[0].ack || cpu_rsp[1].ack) begin
                $display("cpu ack raised after reset with no request made");
                tb_errors++;
            end
        end
        for (int p = 0; p < 2; p++) begin              // write then two reads, last one a hit
            bus_access(p, 1'b1, 16'(p * region_1 + 'h40), 4'hf, 32'hcafe_0000 | p, lat);
            bus_access(p, 1'b0, 16'(p * region_1 + 'h40), 4'hf, '0, lat);
            bus_access(p, 1'b0, 16'(p * region_1 + 'h40), 4'hf, '0, lat);
            if (lat != 2) begin
                $display("[FAIL] cpu%0d hit ack latency = %h, expected %h", p, lat, 2);
                tb_errors++;
            end
        end
        bus_access(0, 1'b1, 16'h0080, 4'h1, 32'h1111_1111, lat);  // byte merge
        bus_access(0, 1'b1, 16'h0080, 4'h6, 32'h2222_2222, lat);
        bus_access(0, 1'b1, 16'h0080, 4'h8, 32'h4444_4444, lat);
        bus_access(0, 1'b0, 16'h0080, 4'hf, '0, lat);
        for (int k = 0; k < 3; k++) begin              // set 0, dirty evictions
            bus_access(0, 1'b1, 16'('h100 + k * 'h40), 4'hf, 32'ha5a5_0000 + k, lat);
        end
        for (int k = 0; k < 3; k++) begin
            bus_access(0, 1'b0, 16'('h100 + k * 'h40), 4'hf, '0, lat);
        end
        fork
            random_ops(0, seed, 200);
            random_ops(1, seed + 1, 200);
        join
        repeat (4) @(negedge clk);                     // last ack through the checker
        if (reads_checked != reads_issued) begin
            $display("checker compared %0d reads but %0d reads were issued",
                     reads_checked, reads_issued);
            tb_errors++;
        end
        $display("checker errors %0d, testbench errors %0d, reads checked %0d",
                 chk_errors, tb_errors, reads_checked);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_cache_subsys

/* verilog.f */
cache_pkg.sv
cache_l1_datapath.sv
cache_l1_controller.sv
cache_l1.sv
mem_arbiter.sv
main_mem.sv
cache_subsys.sv
cache_checker.sv
tb_cache_subsys.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_cache_subsys
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then echo "test did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
